// File: src/rmt_pkg.sv
package rmt_pkg;

	localparam int BEAT_W     = 256;
	localparam int VLAN_W     = 12;
	localparam int CONT_W     = 32;
	localparam int NUM_CONT   = 4;
	localparam int NUM_STAGES = 2;

	// compact single-beat header, fields counted from bit 0
	localparam int ETHERTYPE_LSB  = 240;
	// tci occupies 239:224, id in its low 12 bits
	localparam int VLAN_LSB       = 224;
	localparam int INNER_TYPE_LSB = 208;
	localparam int IP_PROTO_LSB   = 200;
	localparam int UDP_DPORT_LSB  = 184;
	// container 0 is the lowest
	localparam int CONT_LSB       = 32;

	localparam logic [15:0] ETH_TYPE_VLAN = 16'h8100;
	localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
	localparam logic [7:0]  IP_PROTO_UDP  = 8'd17;
	localparam logic [15:0] CTRL_UDP_PORT = 16'h04d2;

	typedef logic [BEAT_W-1:0] beat_t;

	// packet header vector
	typedef struct packed {
		logic [NUM_CONT-1:0][CONT_W-1:0] cont;
		logic [VLAN_W-1:0]               vlan;
	} phv_t;

endpackage

// File: src/rmt_action_pkg.sv
package rmt_action_pkg;

	localparam int TABLE_DEPTH = 16;
	localparam int TABLE_IDX_W = 4;
	localparam int CONT_IDX_W  = 2;
	localparam int IMM_W       = 16;
	localparam int STAGE_ID_W  = 2;

	typedef enum logic [2:0] {
		OP_NOP     = 3'd0,
		OP_ADD     = 3'd1,
		OP_SUB     = 3'd2,
		OP_ADDI    = 3'd3,
		OP_SET     = 3'd4,
		OP_DISCARD = 3'd5
	} opcode_e;

	typedef struct packed {
		opcode_e               op;
		logic [CONT_IDX_W-1:0] dst;
		logic [CONT_IDX_W-1:0] src;
		logic [IMM_W-1:0]      imm;
	} action_t;

	// control payload, low word of a control beat
	localparam int CTRL_ACTION_LSB = 0;
	localparam int CTRL_IDX_LSB    = 24;
	localparam int CTRL_STAGE_LSB  = 28;

endpackage

// File: src/pkt_filter.sv
`timescale 1ns/1ps

module pkt_filter (
	input  logic           clk,
	input  logic           aresetn,
	input  logic           in_valid,
	input  rmt_pkg::beat_t in_data,
	output logic           pkt_valid,
	output rmt_pkg::beat_t pkt_data,
	output logic           ctrl_valid,
	output rmt_pkg::beat_t ctrl_data
);
	import rmt_pkg::*;

	logic [15:0] outer_type;
	logic [15:0] inner_type;
	logic [7:0]  ip_proto;
	logic [15:0] udp_dport;
	logic        is_vlan_udp;
	logic        is_ctrl;
	beat_t       beat_q;

	assign outer_type = in_data[ETHERTYPE_LSB +: 16];
	assign inner_type = in_data[INNER_TYPE_LSB +: 16];
	assign ip_proto   = in_data[IP_PROTO_LSB +: 8];
	assign udp_dport  = in_data[UDP_DPORT_LSB +: 16];

	assign is_vlan_udp = (outer_type == ETH_TYPE_VLAN) && (inner_type == ETH_TYPE_IPV4) &&
		(ip_proto == IP_PROTO_UDP);
	assign is_ctrl = (udp_dport == CTRL_UDP_PORT);

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			pkt_valid  <= 1'b0;
			ctrl_valid <= 1'b0;
		end else begin
			pkt_valid  <= in_valid && is_vlan_udp && !is_ctrl;
			ctrl_valid <= in_valid && is_vlan_udp && is_ctrl;
		end
	end

	// one beat register serves both paths
	always_ff @(posedge clk) begin
		beat_q <= in_data;
	end

	assign pkt_data  = beat_q;
	assign ctrl_data = beat_q;

	a_one_path: assert property (@(posedge clk) disable iff (!aresetn)
		!(pkt_valid && ctrl_valid))
		else $error("filter raised data and control strobes together");

endmodule

// File: src/phv_parser.sv
`timescale 1ns/1ps

module phv_parser (
	input  logic           clk,
	input  logic           aresetn,
	input  logic           pkt_valid,
	input  rmt_pkg::beat_t pkt_data,
	output logic           phv_valid,
	output rmt_pkg::phv_t  phv,
	output rmt_pkg::beat_t beat
);
	import rmt_pkg::*;

	phv_t phv_next;

	// fixed container positions, no header length to walk
	always_comb begin
		phv_next.vlan = pkt_data[VLAN_LSB +: VLAN_W];
		for (int i = 0; i < NUM_CONT; i++) begin
			phv_next.cont[i] = pkt_data[CONT_LSB + i*CONT_W +: CONT_W];
		end
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			phv_valid <= 1'b0;
		end else begin
			phv_valid <= pkt_valid;
		end
	end

	always_ff @(posedge clk) begin
		phv <= phv_next;
		// full beat rides along for the deparser
		beat <= pkt_data;
	end

endmodule

// File: src/match_action_stage.sv
`timescale 1ns/1ps

module match_action_stage #(
	parameter int unsigned STAGE_ID = 0
) (
	input  logic           clk,
	input  logic           aresetn,
	input  logic           ctrl_valid,
	input  rmt_pkg::beat_t ctrl_data,
	input  logic           in_valid,
	input  rmt_pkg::phv_t  in_phv,
	input  rmt_pkg::beat_t in_beat,
	output logic           out_valid,
	output rmt_pkg::phv_t  out_phv,
	output rmt_pkg::beat_t out_beat
);
	import rmt_pkg::*;
	import rmt_action_pkg::*;

	action_t                table_q [TABLE_DEPTH];
	action_t                entry;
	action_t                wr_entry;
	logic [TABLE_IDX_W-1:0] lookup_idx;
	logic [TABLE_IDX_W-1:0] wr_idx;
	logic                   wr_en;
	logic [CONT_W-1:0]      dst_val;
	logic [CONT_W-1:0]      src_val;
	logic [CONT_W-1:0]      imm_ext;
	logic [CONT_W-1:0]      result;
	phv_t                   phv_next;

	// control beat addressed to this stage
	assign wr_en = ctrl_valid &&
		(ctrl_data[CTRL_STAGE_LSB +: STAGE_ID_W] == STAGE_ID_W'(STAGE_ID));
	assign wr_idx   = ctrl_data[CTRL_IDX_LSB +: TABLE_IDX_W];
	assign wr_entry = action_t'(ctrl_data[CTRL_ACTION_LSB +: $bits(action_t)]);

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			for (int i = 0; i < TABLE_DEPTH; i++) begin
				table_q[i] <= '{op: OP_NOP, default: '0};
			end
		end else if (wr_en) begin
			table_q[wr_idx] <= wr_entry;
		end
	end

	// table indexed by the low vlan bits
	assign lookup_idx = in_phv.vlan[TABLE_IDX_W-1:0];
	assign entry      = table_q[lookup_idx];

	assign dst_val = in_phv.cont[entry.dst];
	assign src_val = in_phv.cont[entry.src];
	assign imm_ext = {{(CONT_W-IMM_W){1'b0}}, entry.imm};

	// all arithmetic wraps at container width
	always_comb begin
		result = dst_val;
		case (entry.op)
			OP_ADD: begin
				result = dst_val + src_val;
			end
			OP_SUB: begin
				result = dst_val - src_val;
			end
			OP_ADDI: begin
				result = dst_val + imm_ext;
			end
			OP_SET: begin
				result = imm_ext;
			end
			default: begin
				result = dst_val;
			end
		endcase
	end

	always_comb begin
		phv_next = in_phv;
		phv_next.cont[entry.dst] = result;
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid && (entry.op != OP_DISCARD);
		end
	end

	always_ff @(posedge clk) begin
		out_phv  <= phv_next;
		out_beat <= in_beat;
	end

	// table contents come only from control beats, so garbage payload shows up here
	a_known_op: assert property (@(posedge clk) disable iff (!aresetn)
		in_valid |-> entry.op inside {OP_NOP, OP_ADD, OP_SUB, OP_ADDI, OP_SET, OP_DISCARD})
		else $error("stage %0d looked up undefined opcode %0d", STAGE_ID, entry.op);

endmodule

// File: src/phv_deparser.sv
`timescale 1ns/1ps

module phv_deparser (
	input  logic           clk,
	input  logic           aresetn,
	input  logic           in_valid,
	input  rmt_pkg::phv_t  in_phv,
	input  rmt_pkg::beat_t in_beat,
	output logic           out_valid,
	output rmt_pkg::beat_t out_data
);
	import rmt_pkg::*;

	beat_t merged;

	// overwrite container fields, rest of the header untouched
	always_comb begin
		merged = in_beat;
		for (int i = 0; i < NUM_CONT; i++) begin
			merged[CONT_LSB + i*CONT_W +: CONT_W] = in_phv.cont[i];
		end
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		out_data <= merged;
	end

	a_quiet_after_reset: assert property (@(posedge clk)
		!aresetn |=> !out_valid)
		else $error("deparser output valid right after reset");

endmodule

// File: src/rmt_pipeline.sv
`timescale 1ns/1ps

module rmt_pipeline (
	input  logic           clk,
	input  logic           aresetn,
	input  logic           in_valid,
	input  rmt_pkg::beat_t in_data,
	output logic           out_valid,
	output rmt_pkg::beat_t out_data
);
	import rmt_pkg::*;

	logic  pkt_valid;
	beat_t pkt_data;
	logic  ctrl_valid;
	beat_t ctrl_data;

	// index 0 is the parser output, index k+1 the output of stage k
	logic  stg_valid [NUM_STAGES+1];
	phv_t  stg_phv   [NUM_STAGES+1];
	beat_t stg_beat  [NUM_STAGES+1];

	pkt_filter pkt_filter_inst (
		.clk        (clk),
		.aresetn    (aresetn),
		.in_valid   (in_valid),
		.in_data    (in_data),
		.pkt_valid  (pkt_valid),
		.pkt_data   (pkt_data),
		.ctrl_valid (ctrl_valid),
		.ctrl_data  (ctrl_data)
	);

	phv_parser phv_parser_inst (
		.clk       (clk),
		.aresetn   (aresetn),
		.pkt_valid (pkt_valid),
		.pkt_data  (pkt_data),
		.phv_valid (stg_valid[0]),
		.phv       (stg_phv[0]),
		.beat      (stg_beat[0])
	);

	// control beats reach every stage in the same cycle
	for (genvar k = 0; k < NUM_STAGES; k++) begin : g_stage
		match_action_stage #(
			.STAGE_ID (k)
		) stage_inst (
			.clk        (clk),
			.aresetn    (aresetn),
			.ctrl_valid (ctrl_valid),
			.ctrl_data  (ctrl_data),
			.in_valid   (stg_valid[k]),
			.in_phv     (stg_phv[k]),
			.in_beat    (stg_beat[k]),
			.out_valid  (stg_valid[k+1]),
			.out_phv    (stg_phv[k+1]),
			.out_beat   (stg_beat[k+1])
		);
	end

	phv_deparser phv_deparser_inst (
		.clk       (clk),
		.aresetn   (aresetn),
		.in_valid  (stg_valid[NUM_STAGES]),
		.in_phv    (stg_phv[NUM_STAGES]),
		.in_beat   (stg_beat[NUM_STAGES]),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

endmodule

// File: verification/rmt_tb.sv
`timescale 1ns/1ps

module rmt_tb;
	import rmt_pkg::*;
	import rmt_action_pkg::*;

	// reset, five short tests of about 20 cycles, then 32 table writes and 200 beats
	localparam int STIM_CYCLES = 5 + 5*20 + 32 + 200 + 20;
	localparam int CYCLE_LIMIT = STIM_CYCLES + 100;
	localparam int LATENCY     = 3 + NUM_STAGES;

	logic  clk;
	logic  aresetn;
	logic  in_valid;
	beat_t in_data;
	logic  out_valid;
	beat_t out_data;

	beat_t exp_q [$];
	int    due_q [$];
	beat_t exp_head;
	int    exp_due;
	int    exp_count = 0;
	int    cycle_count = 0;
	int    error_count = 0;
	int    tests_passed = 0;
	int    tests_failed = 0;
	int    test_errors_before = 0;

	// shadow copy of every stage table
	logic [2:0]  tbl_op  [NUM_STAGES][TABLE_DEPTH];
	logic [1:0]  tbl_dst [NUM_STAGES][TABLE_DEPTH];
	logic [1:0]  tbl_src [NUM_STAGES][TABLE_DEPTH];
	logic [15:0] tbl_imm [NUM_STAGES][TABLE_DEPTH];

	rmt_pipeline rmt_pipeline_inst (
		.clk       (clk),
		.aresetn   (aresetn),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Verification failed");
			$finish;
		end
	end

	function automatic void refresh_head();
		exp_count = exp_q.size();
		if (exp_count > 0) begin
			exp_head = exp_q[0];
			exp_due  = due_q[0];
		end
	endfunction

	// head leaves once its output cycle has been checked
	always @(posedge clk) begin
		if (out_valid && exp_q.size() > 0) begin
			exp_q.delete(0);
			due_q.delete(0);
			refresh_head();
		end
	end

	a_out_match: assert property (@(negedge clk) disable iff (!aresetn)
		(out_valid && exp_count > 0) |-> (out_data == exp_head))
		else begin
			error_count++;
			$display("CHECK FAILED at %0t: out_data expected %h, got %h",
				$time, exp_head, out_data);
		end

	a_out_latency: assert property (@(negedge clk) disable iff (!aresetn)
		(out_valid && exp_count > 0) |-> (cycle_count == exp_due))
		else begin
			error_count++;
			$display("CHECK FAILED at %0t: out_valid cycle expected %0d, got %0d",
				$time, exp_due, cycle_count);
		end

	a_no_extra: assert property (@(negedge clk) disable iff (!aresetn)
		out_valid |-> (exp_count > 0))
		else begin
			error_count++;
			$display("at %0t an output beat appeared when no beat was expected", $time);
		end

	// filter rule, table shadowing and container actions
	task automatic model_beat(input beat_t b);
		logic [31:0] cont [NUM_CONT];
		logic [31:0] acc;
		logic [22:0] act;
		logic [3:0]  idx;
		logic [1:0]  stg;
		logic [2:0]  op;
		logic        dropped;
		beat_t       e;
		dropped = 1'b0;
		if (b[ETHERTYPE_LSB +: 16] == ETH_TYPE_VLAN && b[INNER_TYPE_LSB +: 16] == ETH_TYPE_IPV4 &&
			b[IP_PROTO_LSB +: 8] == IP_PROTO_UDP) begin
			if (b[UDP_DPORT_LSB +: 16] == CTRL_UDP_PORT) begin
				stg = b[CTRL_STAGE_LSB +: 2];
				idx = b[CTRL_IDX_LSB +: 4];
				act = b[CTRL_ACTION_LSB +: 23];
				if (int'(stg) < NUM_STAGES) begin
					tbl_op[stg][idx]  = act[22:20];
					tbl_dst[stg][idx] = act[19:18];
					tbl_src[stg][idx] = act[17:16];
					tbl_imm[stg][idx] = act[15:0];
				end
			end else begin
				idx = b[VLAN_LSB +: 4];
				for (int i = 0; i < NUM_CONT; i++) begin
					cont[i] = b[CONT_LSB + i*32 +: 32];
				end
				for (int s = 0; s < NUM_STAGES; s++) begin
					if (!dropped) begin
						op  = tbl_op[s][idx];
						acc = cont[tbl_dst[s][idx]];
						case (op)
							OP_ADD: acc = acc + cont[tbl_src[s][idx]];
							OP_SUB: acc = acc - cont[tbl_src[s][idx]];
							OP_ADDI: acc = acc + {16'h0000, tbl_imm[s][idx]};
							OP_SET: acc = {16'h0000, tbl_imm[s][idx]};
							OP_DISCARD: dropped = 1'b1;
							default: acc = acc;
						endcase
						cont[tbl_dst[s][idx]] = acc;
					end
				end
				if (!dropped) begin
					e = b;
					for (int i = 0; i < NUM_CONT; i++) begin
						e[CONT_LSB + i*32 +: 32] = cont[i];
					end
					exp_q.push_back(e);
					due_q.push_back(cycle_count + LATENCY);
					refresh_head();
				end
			end
		end
	endtask

	task automatic send_beat(input beat_t b);
		@(posedge clk);
		#2;
		in_valid = 1'b1;
		in_data  = b;
		model_beat(b);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#2;
			in_valid = 1'b0;
		end
	endtask

	task automatic drain_pipeline();
		int waited;
		waited = 0;
		idle_cycles(1);
		while (exp_q.size() > 0 && waited < 20) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (exp_q.size() > 0) begin
			error_count++;
			$display("%0d expected beats never reached the output", exp_q.size());
			exp_q.delete();
			due_q.delete();
			refresh_head();
		end
		// lets discarded and dropped beats leave the pipeline too
		idle_cycles(6);
	endtask

	task automatic end_test(input string name);
		if (error_count == test_errors_before) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, error_count - test_errors_before);
		end
		test_errors_before = error_count;
	endtask

	function automatic beat_t rand_bits();
		beat_t b;
		for (int i = 0; i < BEAT_W/32; i++) begin
			b[i*32 +: 32] = $urandom;
		end
		return b;
	endfunction

	function automatic beat_t data_beat(input logic [11:0] vlan);
		beat_t b;
		b = rand_bits();
		b[ETHERTYPE_LSB +: 16]  = ETH_TYPE_VLAN;
		b[VLAN_LSB +: VLAN_W]   = vlan;
		b[INNER_TYPE_LSB +: 16] = ETH_TYPE_IPV4;
		b[IP_PROTO_LSB +: 8]    = IP_PROTO_UDP;
		if (b[UDP_DPORT_LSB +: 16] == CTRL_UDP_PORT) begin
			b[UDP_DPORT_LSB] = ~b[UDP_DPORT_LSB];
		end
		return b;
	endfunction

	function automatic beat_t with_cont(input beat_t b, input int i, input logic [31:0] v);
		beat_t r;
		r = b;
		r[CONT_LSB + i*32 +: 32] = v;
		return r;
	endfunction

	function automatic beat_t ctrl_beat(input int stage, input int idx, input logic [2:0] op,
		input logic [1:0] dst, input logic [1:0] src, input logic [15:0] imm);
		beat_t b;
		b = data_beat(12'h000);
		b[UDP_DPORT_LSB +: 16]  = CTRL_UDP_PORT;
		b[CTRL_STAGE_LSB +: 2]  = stage[1:0];
		b[CTRL_IDX_LSB +: 4]    = idx[3:0];
		b[CTRL_ACTION_LSB +: 23] = {op, dst, src, imm};
		return b;
	endfunction

	initial begin
		beat_t b;
		void'($urandom(32'h65239c1f));
		aresetn  = 1'b0;
		in_valid = 1'b0;
		in_data  = '0;
		for (int s = 0; s < NUM_STAGES; s++) begin
			for (int i = 0; i < TABLE_DEPTH; i++) begin
				tbl_op[s][i]  = OP_NOP;
				tbl_dst[s][i] = 2'd0;
				tbl_src[s][i] = 2'd0;
				tbl_imm[s][i] = 16'h0000;
			end
		end
		refresh_head();
		repeat (5) @(posedge clk);
		#2;
		aresetn = 1'b1;

		for (int n = 0; n < 8; n++) begin
			send_beat(data_beat(12'($urandom)));
		end
		drain_pipeline();
		end_test("1 nop passthrough");

		b = data_beat(12'h021);
		b[ETHERTYPE_LSB +: 16] = 16'h0800;
		send_beat(b);
		b = data_beat(12'h022);
		b[INNER_TYPE_LSB +: 16] = 16'h86dd;
		send_beat(b);
		send_beat(data_beat(12'h023));
		b = data_beat(12'h024);
		b[IP_PROTO_LSB +: 8] = 8'd6;
		send_beat(b);
		// no stage 3 exists, the write lands nowhere
		send_beat(ctrl_beat(3, 4, OP_SET, 2'd0, 2'd0, 16'h5555));
		send_beat(data_beat(12'h025));
		drain_pipeline();
		end_test("2 filter drops");

		send_beat(ctrl_beat(0, 5, OP_ADDI, 2'd0, 2'd0, 16'h1234));
		send_beat(ctrl_beat(1, 5, OP_SET, 2'd1, 2'd0, 16'hbeef));
		send_beat(ctrl_beat(1, 6, OP_ADDI, 2'd2, 2'd0, 16'h0042));
		send_beat(data_beat(12'h005));
		send_beat(data_beat(12'h015));
		send_beat(data_beat(12'h006));
		send_beat(data_beat(12'h007));
		send_beat(data_beat(12'h105));
		drain_pipeline();
		end_test("3 table writes");

		// stage 1 subtracts the sum that stage 0 produced
		send_beat(ctrl_beat(0, 3, OP_ADD, 2'd0, 2'd1, 16'h0000));
		send_beat(ctrl_beat(1, 3, OP_SUB, 2'd2, 2'd0, 16'h0000));
		b = with_cont(data_beat(12'h003), 0, 32'hffff_fff0);
		b = with_cont(b, 1, 32'h0000_0020);
		b = with_cont(b, 2, 32'h0000_0005);
		send_beat(b);
		b = with_cont(data_beat(12'h013), 0, 32'h8000_0000);
		b = with_cont(b, 1, 32'h8000_0000);
		send_beat(b);
		send_beat(data_beat(12'h033));
		drain_pipeline();
		end_test("4 add and sub");

		send_beat(ctrl_beat(0, 10, OP_DISCARD, 2'd0, 2'd0, 16'h0000));
		send_beat(ctrl_beat(1, 11, OP_DISCARD, 2'd0, 2'd0, 16'h0000));
		send_beat(data_beat(12'h009));
		send_beat(data_beat(12'h00a));
		send_beat(data_beat(12'h00b));
		send_beat(data_beat(12'h00c));
		send_beat(data_beat(12'h01a));
		send_beat(data_beat(12'h019));
		drain_pipeline();
		end_test("5 discard");

		for (int s = 0; s < NUM_STAGES; s++) begin
			for (int i = 0; i < TABLE_DEPTH; i++) begin
				send_beat(ctrl_beat(s, i, 3'($urandom_range(5)), 2'($urandom_range(3)),
					2'($urandom_range(3)), 16'($urandom)));
			end
		end
		for (int n = 0; n < 200; n++) begin
			b = data_beat(12'($urandom));
			// roughly one beat in eight fails the filter
			if ($urandom_range(7) == 0) begin
				b[INNER_TYPE_LSB +: 16] = 16'h86dd;
			end
			send_beat(b);
		end
		drain_pipeline();
		end_test("6 random traffic");

		$display("tests passed: %0d, tests failed: %0d, check errors: %0d",
			tests_passed, tests_failed, error_count);
		if (tests_failed == 0 && error_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// File: list.f
src/rmt_pkg.sv
src/rmt_action_pkg.sv
src/pkt_filter.sv
src/phv_parser.sv
src/match_action_stage.sv
src/phv_deparser.sv
src/rmt_pipeline.sv
verification/rmt_tb.sv

// File: run.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
	--top-module rmt_tb --Mdir "$OBJ" -o rmt_sim -f list.f
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

"./$OBJ/rmt_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Verification failed" "$LOG"; then
	exit 1
fi

if ! grep -q "Verification passed" "$LOG"; then
	echo "simulation ended without a result line"
	exit 1
fi

exit 0
